//--- mm_pkg.sv
// heap of 32 blocks, objects of 1 to 4 blocks, one command in flight, collection is not concurrent
package mm_pkg;

	localparam int heap_blocks = 32;
	localparam int addr_w = 5;
	localparam int data_w = 16;
	localparam int max_obj_blocks = 4;
	localparam int root_depth = 8;
	localparam int mark_passes = 10; // graph depth limit
	localparam int gc_trigger = 23; // 70 % of the heap, rounded up
	localparam int count_w = 6;

	localparam int size_w = $clog2(max_obj_blocks + 1);
	localparam int root_w = $clog2(root_depth + 1); // holds 0 to root_depth
	localparam int ridx_w = $clog2(root_depth);
	localparam int pass_w = $clog2(mark_passes);

	typedef enum logic [1:0] {white, grey, black} colour_t;

	typedef enum logic [1:0] {op_alloc, op_read, op_pop_root, op_collect} op_t;

	typedef enum logic [1:0] {st_ok, st_no_space, st_roots_full, st_roots_empty} status_t;

	// a referring object keeps the target head address in data[addr_w-1:0]
	typedef struct packed {
		logic used;
		logic head;
		logic [size_w-1:0] size; // copied into every block of the object
		colour_t colour;
		logic refer;
		logic [data_w-1:0] data;
	} block_t;

	typedef struct packed {
		op_t op;
		logic [size_w-1:0] size;
		logic refer;
		logic root; // push the new head onto the root stack
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] data;
	} cmd_t;

	typedef struct packed {
		status_t status;
		logic [addr_w-1:0] addr;
		block_t blk;
		logic [count_w-1:0] freed;
		logic [count_w-1:0] used;
	} rsp_t;

	typedef struct packed {
		logic we;
		logic [addr_w-1:0] addr;
		block_t wdata;
	} mem_req_t;

endpackage

//--- cmd_port.sv
// four-phase req/ack slave, req is sampled only while ack is low and cmd must be stable with req
module cmd_port (
	input  logic gc,
	input  logic rst,
	input  logic req,
	input  mm_pkg::cmd_t cmd,
	output logic ack,
	output mm_pkg::rsp_t rsp,
	output logic start,
	output mm_pkg::cmd_t op_cmd,
	input  logic done,
	input  mm_pkg::rsp_t op_rsp
);

	typedef enum logic [1:0] {p_idle, p_busy, p_hold} state_t;

	state_t state;

	always_ff @(posedge gc)
	begin
		if (rst)
		begin
			state <= p_idle;
			start <= 1'b0;
			ack <= 1'b0;
		end
		else
		begin
			start <= 1'b0;
			case (state)
				p_idle:
					if (req)
					begin
						start <= 1'b1;
						state <= p_busy;
					end
				p_busy:
					if (done)
					begin
						ack <= 1'b1;
						state <= p_hold;
					end
				p_hold:
					if (!req)
					begin
						ack <= 1'b0; // handshake closes here
						state <= p_idle;
					end
				default: state <= p_idle;
			endcase
		end
	end

	always_ff @(posedge gc)
	begin
		if (state == p_idle && req)
			op_cmd <= cmd;
		if (state == p_busy && done)
			rsp <= op_rsp; // held until the next command
	end

endmodule

//--- heap_store.sv
// 32 block headers in registers, one port, write on the clock edge and read without delay
module heap_store (
	input  logic gc,
	input  logic rst,
	input  mm_pkg::mem_req_t mem,
	output mm_pkg::block_t rdata
);

	mm_pkg::block_t blk_q [mm_pkg::heap_blocks];

	always_ff @(posedge gc)
	begin
		if (rst)
		begin
			for (int i = 0; i < mm_pkg::heap_blocks; i++)
				blk_q[i] <= '0;
		end
		else if (mem.we)
		begin
			blk_q[mem.addr] <= mem.wdata;
		end
	end

	// the allocator and the collector rely on this being combinational
	assign rdata = blk_q[mem.addr];

endmodule

//--- root_table.sv
// root stack of 8 head addresses, a push when full and a pop when empty are ignored
module root_table (
	input  logic gc,
	input  logic rst,
	input  logic push,
	input  logic [mm_pkg::addr_w-1:0] push_addr,
	input  logic pop,
	output logic [mm_pkg::root_w-1:0] count,
	output logic [mm_pkg::addr_w-1:0] top,
	input  logic [mm_pkg::ridx_w-1:0] rd_idx,
	output logic [mm_pkg::addr_w-1:0] rd_addr
);

	logic [mm_pkg::addr_w-1:0] stack_q [mm_pkg::root_depth];
	logic [mm_pkg::root_w-1:0] sp;
	logic [mm_pkg::ridx_w-1:0] top_idx;
	logic can_push;

	assign can_push = push && sp != mm_pkg::root_w'(mm_pkg::root_depth);
	assign top_idx = sp[mm_pkg::ridx_w-1:0] - 1'b1;

	always_ff @(posedge gc)
	begin
		if (rst)
			sp <= '0;
		else if (can_push)
			sp <= sp + 1'b1;
		else if (pop && sp != '0)
			sp <= sp - 1'b1;
	end

	always_ff @(posedge gc)
	begin
		if (can_push)
			stack_q[sp[mm_pkg::ridx_w-1:0]] <= push_addr;
	end

	assign count = sp;
	assign top = stack_q[top_idx]; // meaningless while the stack is empty
	assign rd_addr = stack_q[rd_idx];

endmodule

//--- first_fit_alloc.sv
// first-fit allocator, req must stay stable until alloc_done and size must be 1 to 4
module first_fit_alloc (
	input  logic gc,
	input  logic rst,
	input  logic alloc_start,
	input  mm_pkg::cmd_t req,
	output logic alloc_done,
	output logic alloc_ok,
	output logic [mm_pkg::addr_w-1:0] alloc_addr,
	output mm_pkg::mem_req_t mem,
	input  mm_pkg::block_t rdata,
	output logic push,
	output logic [mm_pkg::addr_w-1:0] push_addr
);

	typedef enum logic [1:0] {a_idle, a_scan, a_write} state_t;

	state_t state;
	logic [mm_pkg::addr_w-1:0] scan_q;
	logic [mm_pkg::addr_w-1:0] base_q;
	logic [mm_pkg::size_w-1:0] run_q;
	logic [mm_pkg::size_w-1:0] wr_q;
	logic [mm_pkg::size_w-1:0] run_next;
	logic fits;
	logic last_wr;
	logic last_blk;

	assign run_next = run_q + 1'b1;
	assign fits = !rdata.used && run_next == req.size; // this block closes a long enough run
	assign last_wr = wr_q == req.size - 1'b1;
	assign last_blk = scan_q == mm_pkg::addr_w'(mm_pkg::heap_blocks - 1);

	assign push = state == a_write && last_wr && req.root;
	assign push_addr = base_q;
	assign alloc_addr = base_q;

	always_comb
	begin
		mem = '0;
		if (state == a_scan)
		begin
			mem.addr = scan_q;
		end
		else if (state == a_write)
		begin
			mem.we = 1'b1;
			mem.addr = base_q + mm_pkg::addr_w'(wr_q);
			mem.wdata.used = 1'b1;
			mem.wdata.head = wr_q == '0;
			mem.wdata.size = req.size;
			mem.wdata.colour = mm_pkg::white;
			mem.wdata.refer = req.refer;
			mem.wdata.data = req.data;
		end
	end

	always_ff @(posedge gc)
	begin
		if (rst)
		begin
			state <= a_idle;
			alloc_done <= 1'b0;
			alloc_ok <= 1'b0;
			scan_q <= '0;
			base_q <= '0;
			run_q <= '0;
			wr_q <= '0;
		end
		else
		begin
			alloc_done <= 1'b0;
			case (state)
				a_idle:
					if (alloc_start)
					begin
						scan_q <= '0;
						run_q <= '0;
						state <= a_scan;
					end
				a_scan:
					if (fits)
					begin
						base_q <= scan_q - mm_pkg::addr_w'(run_q);
						wr_q <= '0;
						state <= a_write;
					end
					else
					begin
						run_q <= rdata.used ? '0 : run_next; // a used block breaks the run
						scan_q <= scan_q + 1'b1;
						if (last_blk)
						begin
							alloc_done <= 1'b1;
							alloc_ok <= 1'b0;
							state <= a_idle;
						end
					end
				a_write:
				begin
					wr_q <= wr_q + 1'b1;
					if (last_wr)
					begin
						alloc_done <= 1'b1;
						alloc_ok <= 1'b1;
						state <= a_idle;
					end
				end
				default: state <= a_idle;
			endcase
		end
	end

endmodule

//--- gc_engine.sv
// stop-the-world tricolour collector, at most 10 mark passes, leaves every survivor white
module gc_engine (
	input  logic gc,
	input  logic rst,
	input  logic gc_start,
	output logic gc_done,
	output logic [mm_pkg::count_w-1:0] gc_freed,
	output mm_pkg::mem_req_t mem,
	input  mm_pkg::block_t rdata,
	output logic [mm_pkg::ridx_w-1:0] rd_idx,
	input  logic [mm_pkg::root_w-1:0] root_count,
	input  logic [mm_pkg::addr_w-1:0] rd_addr
);

	typedef enum logic [2:0] {g_idle, g_shade, g_mark, g_target, g_sweep} state_t;

	state_t state;
	logic [mm_pkg::root_w-1:0] idx_q;
	logic [mm_pkg::addr_w-1:0] scan_q;
	logic [mm_pkg::addr_w-1:0] tgt_q;
	logic [mm_pkg::pass_w-1:0] pass_q;
	logic [mm_pkg::count_w-1:0] freed_q;
	logic found_q;
	logic kill_q;
	logic grey_head;
	logic white_head;
	logic hit_any;
	logic last_blk;
	logic step;
	logic sweep_kill;

	assign rd_idx = idx_q[mm_pkg::ridx_w-1:0];
	assign gc_freed = freed_q;

	assign grey_head = rdata.used && rdata.head && rdata.colour == mm_pkg::grey;
	assign white_head = rdata.used && rdata.head && rdata.colour == mm_pkg::white;
	assign last_blk = scan_q == mm_pkg::addr_w'(mm_pkg::heap_blocks - 1);
	assign hit_any = found_q || (state == g_mark && grey_head);

	// body blocks follow the verdict taken at their head
	assign sweep_kill = rdata.head ? rdata.colour == mm_pkg::white : kill_q;

	// move on to the next block of the mark pass
	assign step = (state == g_mark && !(grey_head && rdata.refer)) || state == g_target;

	always_comb
	begin
		mem = '0;
		mem.wdata = rdata;
		case (state)
			g_shade:
			begin
				mem.addr = rd_addr;
				mem.we = idx_q != root_count && rdata.used;
				mem.wdata.colour = mm_pkg::grey;
			end
			g_mark:
			begin
				mem.addr = scan_q;
				mem.we = grey_head;
				mem.wdata.colour = mm_pkg::black;
			end
			g_target:
			begin
				mem.addr = tgt_q;
				mem.we = white_head; // black or grey targets are already reached
				mem.wdata.colour = mm_pkg::grey;
			end
			g_sweep:
			begin
				mem.addr = scan_q;
				mem.we = rdata.used;
				if (sweep_kill)
					mem.wdata = '0;
				else
					mem.wdata.colour = mm_pkg::white;
			end
			default: mem.we = 1'b0;
		endcase
	end

	always_ff @(posedge gc)
	begin
		if (rst)
		begin
			state <= g_idle;
			gc_done <= 1'b0;
			idx_q <= '0;
			scan_q <= '0;
			tgt_q <= '0;
			pass_q <= '0;
			freed_q <= '0;
			found_q <= 1'b0;
			kill_q <= 1'b0;
		end
		else
		begin
			gc_done <= 1'b0;
			case (state)
				g_idle:
					if (gc_start)
					begin
						idx_q <= '0;
						freed_q <= '0;
						state <= g_shade;
					end
				g_shade:
					if (idx_q == root_count)
					begin
						scan_q <= '0;
						pass_q <= '0;
						found_q <= 1'b0;
						state <= g_mark;
					end
					else
						idx_q <= idx_q + 1'b1;
				g_mark:
					if (grey_head && rdata.refer)
					begin
						found_q <= 1'b1;
						tgt_q <= rdata.data[mm_pkg::addr_w-1:0];
						state <= g_target;
					end
				g_sweep:
				begin
					if (rdata.used && rdata.head)
						kill_q <= rdata.colour == mm_pkg::white;
					if (rdata.used && sweep_kill)
						freed_q <= freed_q + 1'b1;
					scan_q <= scan_q + 1'b1;
					if (last_blk)
					begin
						gc_done <= 1'b1;
						state <= g_idle;
					end
				end
				default: state <= state;
			endcase

			if (step)
			begin
				scan_q <= scan_q + 1'b1; // wraps to 0 at the end of a pass
				if (last_blk)
				begin
					found_q <= 1'b0;
					pass_q <= pass_q + 1'b1;
					if (!hit_any || pass_q == mm_pkg::pass_w'(mm_pkg::mark_passes - 1))
						state <= g_sweep;
					else
						state <= g_mark;
				end
				else
				begin
					found_q <= hit_any;
					state <= g_mark;
				end
			end
		end
	end

endmodule

//--- heap_ctrl.sv
// command sequencer, op_cmd must stay stable from start to done
module heap_ctrl (
	input  logic gc,
	input  logic rst,
	input  logic start,
	input  mm_pkg::cmd_t op_cmd,
	output logic done,
	output mm_pkg::rsp_t op_rsp,
	output mm_pkg::mem_req_t mem,
	input  mm_pkg::block_t rdata,
	output logic alloc_start,
	input  logic alloc_done,
	input  logic alloc_ok,
	input  logic [mm_pkg::addr_w-1:0] alloc_addr,
	input  mm_pkg::mem_req_t alloc_mem,
	output logic gc_start,
	input  logic gc_done,
	input  logic [mm_pkg::count_w-1:0] gc_freed,
	input  mm_pkg::mem_req_t gc_mem,
	output logic pop,
	input  logic [mm_pkg::root_w-1:0] root_count,
	input  logic [mm_pkg::addr_w-1:0] root_top
);

	typedef enum logic [1:0] {c_idle, c_alloc, c_gc} state_t;

	state_t state;
	logic [mm_pkg::count_w-1:0] used_q;
	logic [mm_pkg::count_w-1:0] used_next;
	logic [mm_pkg::count_w-1:0] freed_q;
	logic [mm_pkg::addr_w-1:0] addr_q;
	mm_pkg::status_t status_q;
	mm_pkg::block_t blk_q;
	logic do_cmd;
	logic roots_full;

	assign do_cmd = state == c_idle && start;
	assign roots_full = op_cmd.root && root_count == mm_pkg::root_w'(mm_pkg::root_depth);
	assign used_next = used_q + mm_pkg::count_w'(op_cmd.size);

	assign alloc_start = do_cmd && op_cmd.op == mm_pkg::op_alloc && !roots_full;
	assign pop = do_cmd && op_cmd.op == mm_pkg::op_pop_root && root_count != '0;
	assign gc_start = (do_cmd && op_cmd.op == mm_pkg::op_collect)
		|| (state == c_alloc && alloc_done && alloc_ok
		&& used_next >= mm_pkg::count_w'(mm_pkg::gc_trigger)); // automatic collection

	assign op_rsp.status = status_q;
	assign op_rsp.addr = addr_q;
	assign op_rsp.blk = blk_q;
	assign op_rsp.freed = freed_q;
	assign op_rsp.used = used_q;

	always_comb
	begin
		case (state)
			c_alloc: mem = alloc_mem;
			c_gc: mem = gc_mem;
			default:
			begin
				mem = '0;
				mem.addr = op_cmd.addr; // read path
			end
		endcase
	end

	always_ff @(posedge gc)
	begin
		if (rst)
		begin
			state <= c_idle;
			done <= 1'b0;
			used_q <= '0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				c_idle:
					if (start)
					begin
						status_q <= mm_pkg::st_ok;
						addr_q <= '0;
						blk_q <= '0;
						freed_q <= '0;
						case (op_cmd.op)
							mm_pkg::op_read:
							begin
								blk_q <= rdata;
								done <= 1'b1;
							end
							mm_pkg::op_pop_root:
							begin
								if (root_count == '0)
									status_q <= mm_pkg::st_roots_empty;
								else
									addr_q <= root_top;
								done <= 1'b1;
							end
							mm_pkg::op_alloc:
								if (roots_full)
								begin
									status_q <= mm_pkg::st_roots_full;
									done <= 1'b1;
								end
								else
									state <= c_alloc;
							default: state <= c_gc;
						endcase
					end
				c_alloc:
					if (alloc_done)
					begin
						if (!alloc_ok)
						begin
							status_q <= mm_pkg::st_no_space;
							done <= 1'b1;
							state <= c_idle;
						end
						else
						begin
							used_q <= used_next;
							addr_q <= alloc_addr;
							if (gc_start)
								state <= c_gc;
							else
							begin
								done <= 1'b1;
								state <= c_idle;
							end
						end
					end
				c_gc:
					if (gc_done)
					begin
						used_q <= used_q - gc_freed;
						freed_q <= gc_freed;
						done <= 1'b1;
						state <= c_idle;
					end
				default: state <= c_idle;
			endcase
		end
	end

endmodule

//--- mm_top.sv
// managed heap top level, host talks four-phase req/ack and holds cmd stable while req is high
module mm_top (
	input  logic gc,
	input  logic rst,
	input  logic req,
	input  mm_pkg::cmd_t cmd,
	output logic ack,
	output mm_pkg::rsp_t rsp
);

	logic start;
	logic done;
	mm_pkg::cmd_t op_cmd;
	mm_pkg::rsp_t op_rsp;
	mm_pkg::mem_req_t mem;
	mm_pkg::mem_req_t alloc_mem;
	mm_pkg::mem_req_t gc_mem;
	mm_pkg::block_t rdata;
	logic alloc_start;
	logic alloc_done;
	logic alloc_ok;
	logic [mm_pkg::addr_w-1:0] alloc_addr;
	logic gc_start;
	logic gc_done;
	logic [mm_pkg::count_w-1:0] gc_freed;
	logic push;
	logic [mm_pkg::addr_w-1:0] push_addr;
	logic pop;
	logic [mm_pkg::root_w-1:0] root_count;
	logic [mm_pkg::addr_w-1:0] root_top;
	logic [mm_pkg::ridx_w-1:0] rd_idx;
	logic [mm_pkg::addr_w-1:0] rd_addr;

	cmd_port u_cmd_port (.gc, .rst, .req, .cmd, .ack, .rsp, .start, .op_cmd, .done, .op_rsp);

	heap_ctrl u_heap_ctrl (
		.gc, .rst, .start, .op_cmd, .done, .op_rsp, .mem, .rdata,
		.alloc_start, .alloc_done, .alloc_ok, .alloc_addr, .alloc_mem,
		.gc_start, .gc_done, .gc_freed, .gc_mem,
		.pop, .root_count, .root_top
	);

	heap_store u_heap_store (.gc, .rst, .mem, .rdata);

	root_table u_root_table (
		.gc, .rst, .push, .push_addr, .pop,
		.count(root_count), .top(root_top), .rd_idx, .rd_addr
	);

	first_fit_alloc u_alloc (
		.gc, .rst, .alloc_start, .req(op_cmd), .alloc_done, .alloc_ok, .alloc_addr,
		.mem(alloc_mem), .rdata, .push, .push_addr
	);

	gc_engine u_gc_engine (
		.gc, .rst, .gc_start, .gc_done, .gc_freed, .mem(gc_mem), .rdata,
		.rd_idx, .root_count, .rd_addr
	);

endmodule

//--- tb_mm_model.svh
// reference model of the heap and the root stack that lives inside tb_mm and keeps every colour white between commands
`ifndef TB_MM_MODEL_SVH
`define TB_MM_MODEL_SVH

mm_pkg::block_t heap_m [mm_pkg::heap_blocks];
logic [mm_pkg::addr_w-1:0] roots_m [$]; // back of the queue is the top of the stack
int used_m;

function automatic void clear_model();
	for (int a = 0; a < mm_pkg::heap_blocks; a++)
		heap_m[a] = '0;
	roots_m.delete();
	used_m = 0;
endfunction

function automatic bit is_head(int a);
	return heap_m[a].used && heap_m[a].head;
endfunction

// lowest base of n free blocks in a row, -1 when no such run exists
function automatic int first_fit(int n);
	bit free_run;
	for (int b = 0; b + n <= mm_pkg::heap_blocks; b++)
	begin
		free_run = 1'b1;
		for (int i = 0; i < n; i++)
			if (heap_m[b + i].used)
				free_run = 1'b0;
		if (free_run)
			return b;
	end
	return -1;
endfunction

// shade the roots, mark in address order for at most mark_passes passes, then sweep
function automatic int collect_model();
	mm_pkg::colour_t col [mm_pkg::heap_blocks];
	int t;
	int freed;
	bit found;
	bit kill;
	freed = 0;
	kill = 1'b0;
	for (int a = 0; a < mm_pkg::heap_blocks; a++)
		col[a] = mm_pkg::white;
	foreach (roots_m[i])
		if (heap_m[roots_m[i]].used)
			col[roots_m[i]] = mm_pkg::grey;
	for (int p = 0; p < mm_pkg::mark_passes; p++)
	begin
		found = 1'b0;
		for (int a = 0; a < mm_pkg::heap_blocks; a++)
		begin
			if (is_head(a) && col[a] == mm_pkg::grey)
			begin
				found = 1'b1;
				col[a] = mm_pkg::black;
				t = int'(heap_m[a].data[mm_pkg::addr_w-1:0]);
				if (heap_m[a].refer && is_head(t) && col[t] == mm_pkg::white)
					col[t] = mm_pkg::grey; // a lower target waits for the next pass
			end
		end
		if (!found)
			break;
	end
	for (int a = 0; a < mm_pkg::heap_blocks; a++)
	begin
		if (heap_m[a].used)
		begin
			if (heap_m[a].head)
				kill = col[a] == mm_pkg::white;
			if (kill)
			begin
				heap_m[a] = '0;
				freed++;
			end
		end
	end
	used_m -= freed;
	return freed;
endfunction

function automatic mm_pkg::rsp_t ref_response(mm_pkg::cmd_t c);
	mm_pkg::rsp_t r;
	int base;
	r = '0;
	r.status = mm_pkg::st_ok;
	case (c.op)
		mm_pkg::op_read:
			r.blk = heap_m[c.addr];
		mm_pkg::op_pop_root:
			if (roots_m.size() == 0)
				r.status = mm_pkg::st_roots_empty;
			else
				r.addr = roots_m.pop_back();
		mm_pkg::op_collect:
			r.freed = mm_pkg::count_w'(collect_model());
		default:
			if (c.root && roots_m.size() == mm_pkg::root_depth)
				r.status = mm_pkg::st_roots_full;
			else
			begin
				base = first_fit(int'(c.size));
				if (base < 0)
					r.status = mm_pkg::st_no_space;
				else
				begin
					for (int i = 0; i < int'(c.size); i++)
					begin
						heap_m[base + i].used = 1'b1;
						heap_m[base + i].head = i == 0;
						heap_m[base + i].size = c.size;
						heap_m[base + i].colour = mm_pkg::white;
						heap_m[base + i].refer = c.refer;
						heap_m[base + i].data = c.data;
					end
					r.addr = mm_pkg::addr_w'(base);
					if (c.root)
						roots_m.push_back(r.addr);
					used_m += int'(c.size);
					if (used_m >= mm_pkg::gc_trigger)
						r.freed = mm_pkg::count_w'(collect_model()); // the new root is shaded too
				end
			end
	endcase
	r.used = mm_pkg::count_w'(used_m);
	return r;
endfunction

`endif

//--- tb_mm.sv
// testbench for mm_top that stops at the first mismatch, runs directed cases and then 120 random commands
module tb_mm;

	localparam int directed_cmds = 70; // the directed part issues 67 commands
	localparam int random_cmds = 120;
	localparam int cycles_per_cmd = 2000;
	localparam int timeout_cycles = cycles_per_cmd * (directed_cmds + random_cmds);

	logic gc;
	logic rst;
	logic req;
	mm_pkg::cmd_t cmd;
	logic ack;
	mm_pkg::rsp_t rsp;

	mm_pkg::rsp_t exp_q [$];
	mm_pkg::rsp_t got_q [$];
	mm_pkg::rsp_t exp_r;
	mm_pkg::rsp_t got_r;
	mm_pkg::rsp_t last_rsp;
	logic [31:0] lfsr = 32'h2edcd0d1;
	int cycles = 0;

	`include "tb_mm_model.svh"

	mm_top DUT (.gc, .rst, .req, .cmd, .ack, .rsp);

	initial
	begin
		gc = 1'b0;
		forever #2 gc = ~gc;
	end

	task automatic end_with_failure();
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_status(string name, mm_pkg::status_t exp, mm_pkg::status_t got);
		if (exp !== got)
		begin
			$display("FAILED t=%0t %s expected %s got %s", $time, name, exp.name(), got.name());
			end_with_failure();
		end
	endtask

	task automatic check_addr(string name, logic [mm_pkg::addr_w-1:0] exp,
		logic [mm_pkg::addr_w-1:0] got);
		if (exp !== got)
		begin
			$display("FAILED t=%0t %s expected %0d got %0d", $time, name, exp, got);
			end_with_failure();
		end
	endtask

	task automatic check_block(string name, mm_pkg::block_t exp, mm_pkg::block_t got);
		if (exp !== got)
		begin
			$display("FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
			end_with_failure();
		end
	endtask

	task automatic check_count(string name, logic [mm_pkg::count_w-1:0] exp,
		logic [mm_pkg::count_w-1:0] got);
		if (exp !== got)
		begin
			$display("FAILED t=%0t %s expected %0d got %0d", $time, name, exp, got);
			end_with_failure();
		end
	endtask

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h80200003;
		return b;
	endfunction

	function automatic int rand_bits(int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++)
			v = (v << 1) | int'(lfsr_bit());
		return v;
	endfunction

	// a live head chosen from the model, -1 while the heap is empty
	function automatic int pick_head();
		int heads [$];
		for (int a = 0; a < mm_pkg::heap_blocks; a++)
			if (is_head(a))
				heads.push_back(a);
		if (heads.size() == 0)
			return -1;
		return heads[rand_bits(5) % heads.size()];
	endfunction

	// one four-phase transfer, the expected response is taken before the DUT sees the command
	task automatic run_cmd(mm_pkg::cmd_t c);
		exp_q.push_back(ref_response(c));
		@(negedge gc);
		cmd = c;
		req = 1'b1;
		@(negedge gc);
		while (!ack)
			@(negedge gc);
		last_rsp = rsp;
		got_q.push_back(rsp);
		req = 1'b0;
		@(negedge gc);
		while (ack)
			@(negedge gc);
	endtask

	task automatic alloc_obj(int size, bit refer, bit root, logic [mm_pkg::data_w-1:0] data);
		mm_pkg::cmd_t c;
		c = '0;
		c.op = mm_pkg::op_alloc;
		c.size = mm_pkg::size_w'(size);
		c.refer = refer;
		c.root = root;
		c.data = data;
		run_cmd(c);
	endtask

	task automatic read_hdr(int addr);
		mm_pkg::cmd_t c;
		c = '0;
		c.op = mm_pkg::op_read;
		c.addr = mm_pkg::addr_w'(addr);
		run_cmd(c);
	endtask

	task automatic pop_root();
		mm_pkg::cmd_t c;
		c = '0;
		c.op = mm_pkg::op_pop_root;
		run_cmd(c);
	endtask

	task automatic collect_now();
		mm_pkg::cmd_t c;
		c = '0;
		c.op = mm_pkg::op_collect;
		run_cmd(c);
	endtask

	task automatic run_random(int n);
		int pick;
		int tgt;
		int size;
		bit refer;
		bit root;
		logic [mm_pkg::data_w-1:0] data;
		for (int i = 0; i < n; i++)
		begin
			pick = rand_bits(3);
			if (pick < 5)
			begin
				size = rand_bits(2) + 1;
				refer = lfsr_bit();
				root = lfsr_bit() & lfsr_bit(); // roots on a quarter of the objects
				data = mm_pkg::data_w'(rand_bits(mm_pkg::data_w));
				tgt = pick_head();
				if (tgt < 0)
					refer = 1'b0;
				else if (refer)
					data[mm_pkg::addr_w-1:0] = mm_pkg::addr_w'(tgt);
				alloc_obj(size, refer, root, data);
			end
			else if (pick == 5)
				read_hdr(rand_bits(mm_pkg::addr_w));
			else if (pick == 6)
				pop_root();
			else
				collect_now();
		end
	endtask

	// each captured response is compared with the model on the next rising edge
	always @(posedge gc)
	begin
		if (got_q.size() != 0)
		begin
			exp_r = exp_q.pop_front();
			got_r = got_q.pop_front();
			check_status("rsp.status", exp_r.status, got_r.status);
			check_addr("rsp.addr", exp_r.addr, got_r.addr);
			check_block("rsp.blk", exp_r.blk, got_r.blk);
			check_count("rsp.freed", exp_r.freed, got_r.freed);
			check_count("rsp.used", exp_r.used, got_r.used);
		end
	end

	always @(posedge gc)
	begin
		cycles = cycles + 1;
		if (cycles >= timeout_cycles)
		begin
			$display("run timed out after %0d cycles before all commands finished", cycles);
			end_with_failure();
		end
	end

	initial
	begin
		rst = 1'b1;
		req = 1'b0;
		cmd = '0;
		clear_model();
		repeat (4) @(posedge gc);
		@(negedge gc);
		rst = 1'b0;

		for (int a = 0; a < mm_pkg::heap_blocks; a++)
			read_hdr(a);
		pop_root();

		// sizes 1 to 4 packed from address 0
		alloc_obj(1, 1'b0, 1'b1, 16'h1111);
		alloc_obj(2, 1'b0, 1'b0, 16'h2222);
		alloc_obj(3, 1'b0, 1'b1, 16'h3333);
		alloc_obj(4, 1'b0, 1'b0, 16'h4444);
		read_hdr(0);
		read_hdr(1);
		read_hdr(2);
		read_hdr(3);
		read_hdr(6);
		read_hdr(9);

		// the collection opens holes at 1 and 6 that the next objects fill
		collect_now();
		alloc_obj(2, 1'b0, 1'b0, 16'h5555);
		alloc_obj(1, 1'b0, 1'b0, 16'h6666);
		read_hdr(1);

		// chain from a root through two referring objects, one root popped before collecting
		alloc_obj(1, 1'b0, 1'b0, 16'h7000);
		alloc_obj(2, 1'b1, 1'b0, 16'h0a07);
		alloc_obj(1, 1'b1, 1'b1, 16'h0b08);
		alloc_obj(3, 1'b0, 1'b1, 16'h8888);
		pop_root();
		collect_now();
		read_hdr(7);
		read_hdr(8);
		read_hdr(10);

		// fill the root stack, overflow it, then pop in reverse order
		for (int i = 0; i < 5; i++)
			alloc_obj(1, 1'b0, 1'b1, 16'h9000 + 16'(i));
		alloc_obj(1, 1'b0, 1'b1, 16'h9999);
		pop_root();
		pop_root();

		// the third object reaches the trigger while garbage is present
		alloc_obj(4, 1'b0, 1'b0, 16'hc001);
		alloc_obj(4, 1'b0, 1'b0, 16'hc002);
		alloc_obj(4, 1'b0, 1'b0, 16'hc003);
		if (last_rsp.freed == '0)
		begin
			$display("automatic collection freed no blocks although garbage existed");
			end_with_failure();
		end

		run_random(random_cmds);
		@(negedge gc);
		@(negedge gc);
		if (exp_q.size() == 0 && got_q.size() == 0)
		begin
			$display("sim passed");
			$finish;
		end
		else
		begin
			$display("%0d responses were never compared", exp_q.size());
			end_with_failure();
		end
	end

endmodule

//--- mm_top.f
+incdir+.
mm_pkg.sv
cmd_port.sv
heap_store.sv
root_table.sv
first_fit_alloc.sv
gc_engine.sv
heap_ctrl.sv
mm_top.sv
tb_mm.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_mm
FILELIST ?= mm_top.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
